//--- compile.f
+incdir+logic
logic/ac97_link_pkg.sv
logic/codec_reg_pkg.sv
logic/ac97_frame_tx.sv
logic/ac97_frame_rx.sv
logic/codec_init_sequencer.sv
logic/ac97_audio_top.sv
bench/ac97_audio_assertions.sv
bench/ac97_audio_checker.sv
bench/ac97_audio_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ac97 controller simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module ac97_audio_tb \
   -f compile.f -o ac97_sim

output=$(./obj_dir/ac97_sim +verilator+error+limit+100 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
   exit 0
fi
exit 1

//--- bench/ac97_audio_tb.sv
// ac97 controller testbench
// clk and bit clock, reset, xorshift stimulus
// codec model on sdata_in, checker and assertions
// timeout and closing line

`timescale 1ns/1ps
`default_nettype none

`include "ac97_params.svh"

module ac97_audio_tb;

   localparam int RUN_FRAMES = 40;
   localparam int HOLD_FRAMES = 4;
   // 8 clk per bit clock
   localparam int FRAME_CLKS = `AC97_FRAME_BITS * 8;
   // run plus margin plus codec reset hold
   localparam int TIMEOUT_CYCLES = (RUN_FRAMES + 8) * FRAME_CLKS + `AC97_RESET_HOLD;

   logic clk;
   logic reset;
   logic ac97_bit_clock;
   logic ac97_sdata_in;
   codec_reg_pkg::volume_t volume;
   codec_reg_pkg::rec_source_t record_source;
   ac97_link_pkg::pcm_sample_t audio_out_data;
   ac97_link_pkg::pcm_sample_t audio_in_data;
   logic ready;
   logic audio_reset_b;
   logic ac97_sdata_out;
   logic ac97_synch;

   logic [31:0] rng_state;
   int ready_count = 0;
   int cycle_count = 0;
   logic run_done;
   int checker_errors;
   int frames_decoded;

   // handed to the checker
   ac97_link_pkg::slot_word_t codec_left;
   int codec_left_count = 0;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   ac97_audio_top ac97_audio_top_i (
      .clk            (clk),
      .reset          (reset),
      .volume         (volume),
      .record_source  (record_source),
      .audio_out_data (audio_out_data),
      .audio_in_data  (audio_in_data),
      .ready          (ready),
      .audio_reset_b  (audio_reset_b),
      .ac97_bit_clock (ac97_bit_clock),
      .ac97_sdata_in  (ac97_sdata_in),
      .ac97_sdata_out (ac97_sdata_out),
      .ac97_synch     (ac97_synch)
   );

   ac97_audio_checker ac97_audio_checker_i (
      .clk              (clk),
      .reset            (reset),
      .ac97_bit_clock   (ac97_bit_clock),
      .volume           (volume),
      .record_source    (record_source),
      .audio_out_data   (audio_out_data),
      .audio_in_data    (audio_in_data),
      .ready            (ready),
      .audio_reset_b    (audio_reset_b),
      .ac97_sdata_out   (ac97_sdata_out),
      .ac97_synch       (ac97_synch),
      .codec_left       (codec_left),
      .codec_left_count (codec_left_count),
      .run_done         (run_done),
      .error_count      (checker_errors),
      .frames_decoded   (frames_decoded)
   );

   bind ac97_audio_top ac97_audio_assertions ac97_audio_assertions_i (
      .clk            (clk),
      .reset          (reset),
      .ready          (ready),
      .audio_reset_b  (audio_reset_b),
      .ac97_bit_clock (ac97_bit_clock),
      .ac97_synch     (ac97_synch)
   );

   ////////////////////
   // clocks
   ////////////////////

   initial clk = 1'b0;
   always #5 clk = ~clk;

   initial ac97_bit_clock = 1'b0;
   always #40 ac97_bit_clock = ~ac97_bit_clock;

   ////////////////////
   // stimulus
   ////////////////////

   initial begin
      rng_state = 32'h303bf341;
      rng_state = xorshift32(rng_state);
      reset = 1'b1;
      run_done = 1'b0;
      ac97_sdata_in = 1'b0;
      codec_left = '0;
      volume = rng_state[4:0];
      record_source = rng_state[7:5];
      audio_out_data = rng_state[31:16];
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      wait (ready_count >= RUN_FRAMES);
      @(posedge clk);
      run_done <= 1'b1;
      repeat (4) @(posedge clk);
      $display("errors: checker %0d, assertions %0d, timeout 0, frames %0d",
               checker_errors, ac97_audio_top_i.ac97_audio_assertions_i.failure_count,
               frames_decoded);
      if (checker_errors == 0 && ac97_audio_top_i.ac97_audio_assertions_i.failure_count == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // new inputs every few frames, on a ready pulse
   always @(posedge clk) begin
      if (!reset && ready) begin
         ready_count = ready_count + 1;
         if (ready_count % HOLD_FRAMES == 0) begin
            rng_state = xorshift32(rng_state);
            volume <= rng_state[4:0];
            record_source <= rng_state[7:5];
            audio_out_data <= rng_state[31:16];
         end
      end
   end

   ////////////////////
   // codec model
   ////////////////////

   // follows the controller's bit index, drives msb first
   always @(posedge ac97_bit_clock) begin : codec_model
      ac97_link_pkg::bit_index_t idx;
      ac97_link_pkg::slot_word_t left_word;
      ac97_link_pkg::slot_word_t right_word;
      #1;
      idx = ac97_audio_top_i.bit_index;
      if (idx == 8'd57) begin
         rng_state = xorshift32(rng_state);
         left_word = rng_state[19:0];
      end
      if (idx == 8'd77) begin
         // left word complete
         codec_left = left_word;
         codec_left_count = codec_left_count + 1;
         rng_state = xorshift32(rng_state);
         right_word = rng_state[19:0];
      end
      if (idx >= 8'd57 && idx <= 8'd76)
         ac97_sdata_in <= left_word[8'd19 - (idx - 8'd57)];
      else if (idx >= 8'd77 && idx <= 8'd96)
         ac97_sdata_in <= right_word[8'd19 - (idx - 8'd77)];
      else
         ac97_sdata_in <= 1'b0;
   end

   ////////////////////
   // timeout
   ////////////////////

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d clk cycles", TIMEOUT_CYCLES);
         $display("errors: checker %0d, assertions %0d, timeout 1, frames %0d",
                  checker_errors, ac97_audio_top_i.ac97_audio_assertions_i.failure_count,
                  frames_decoded);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- bench/ac97_audio_checker.sv
// ac97 controller checker
// reset and hold timing, frame decoder on sdata_out
// reference functions for commands and pcm slots
// capture check on each ready pulse, error count

`timescale 1ns/1ps
`default_nettype none

`include "ac97_params.svh"

module ac97_audio_checker (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         ac97_bit_clock,
   input  codec_reg_pkg::volume_t       volume,
   input  codec_reg_pkg::rec_source_t   record_source,
   input  ac97_link_pkg::pcm_sample_t   audio_out_data,
   input  ac97_link_pkg::pcm_sample_t   audio_in_data,
   input  logic                         ready,
   input  logic                         audio_reset_b,
   input  logic                         ac97_sdata_out,
   input  logic                         ac97_synch,
   input  ac97_link_pkg::slot_word_t    codec_left,
   input  int                           codec_left_count,
   input  logic                         run_done,
   output int                           error_count,
   output int                           frames_decoded
);

   realtime reset_fall_time;
   logic    reset_fall_seen = 1'b0;
   logic    reset_b_rise_ok = 1'b0;
   int      hold_cycles = 0;
   logic    idle_reported = 1'b0;

   // playback sample tracking, written on clk only
   ac97_link_pkg::pcm_sample_t cur_sample = '0;
   ac97_link_pkg::pcm_sample_t prev_sample = '0;
   int change_id = 0;

   // decoder state, written on the bit clock only
   logic [255:0] frame_bits;
   logic prev_synch = 1'b0;
   logic synced = 1'b0;
   int   pos = 0;
   int   high_len = 0;
   int   seen_change_id = 0;
   int   age = 0;
   int   ready_seen = 0;
   logic seen_write [16];

   // values in force when the current frame was latched
   codec_reg_pkg::volume_t     frame_volume;
   codec_reg_pkg::rec_source_t frame_source;
   ac97_link_pkg::pcm_sample_t frame_cur;
   ac97_link_pkg::pcm_sample_t frame_prev;
   int frame_age;

   initial begin
      error_count = 0;
      frames_decoded = 0;
      for (int i = 0; i < 16; i++)
         seen_write[i] = 1'b0;
   end

   ////////////////////
   // reference
   ////////////////////

   // {address, data} for one sequencer step
   function automatic logic [23:0] expected_command(input int step,
                                                    input codec_reg_pkg::volume_t vol,
                                                    input codec_reg_pkg::rec_source_t src);
      logic [4:0] atten;
      atten = 5'd31 - vol;
      case (step)
         codec_reg_pkg::hp_volume:   return {8'h04, 3'b000, atten, 3'b000, atten};
         codec_reg_pkg::pcm_volume:  return {8'h18, 16'h0808};
         codec_reg_pkg::rec_select:  return {8'h1A, 5'b00000, src, 5'b00000, src};
         codec_reg_pkg::rec_gain:    return {8'h1C, 16'h0F0F};
         codec_reg_pkg::mic_gain:    return {8'h0E, 16'h8048};
         codec_reg_pkg::beep_volume: return {8'h0A, 16'h0000};
         codec_reg_pkg::pcm_bypass:  return {8'h20, 16'h8000};
         default:                    return {8'h80, 16'h0000};
      endcase
   endfunction

   function automatic logic is_write_step(input int step);
      return expected_command(step, '0, '0) != {8'h80, 16'h0000};
   endfunction

   // sample left-justified, four zero bits below
   function automatic ac97_link_pkg::slot_word_t expected_pcm_slot(
         input ac97_link_pkg::pcm_sample_t sample);
      return {sample, 4'h0};
   endfunction

   // 20 bits msb first from the given frame position
   function automatic ac97_link_pkg::slot_word_t slot_field(input logic [255:0] bits,
                                                            input int first);
      ac97_link_pkg::slot_word_t w;
      for (int i = 0; i < `AC97_SLOT_BITS; i++)
         w[`AC97_SLOT_BITS-1-i] = bits[first+i];
      return w;
   endfunction

   ////////////////////
   // reset timing
   ////////////////////

   always @(negedge reset) begin
      reset_fall_time = $realtime;
      reset_fall_seen = 1'b1;
   end

   always @(posedge audio_reset_b) begin
      if (!reset_fall_seen || ($realtime - reset_fall_time) != `AC97_RESET_HOLD * 10.0) begin
         $display("audio_reset_b rose %0t after reset fell, not after %0d clk cycles",
                  $realtime - reset_fall_time, `AC97_RESET_HOLD);
         error_count++;
      end else begin
         reset_b_rise_ok = 1'b1;
      end
   end

   // link quiet while the codec is held, bit side needs a few edges
   always @(posedge clk) begin
      if (reset) begin
         hold_cycles = 0;
      end else if (!audio_reset_b) begin
         hold_cycles++;
         if (hold_cycles >= 32 && !idle_reported &&
             (ready !== 1'b0 || ac97_synch !== 1'b0 || ac97_sdata_out !== 1'b0)) begin
            $display("ready, ac97_synch or ac97_sdata_out not 0 during codec reset");
            idle_reported = 1'b1;
            error_count++;
         end
      end
   end

   // playback changes seen on clk
   always @(posedge clk) begin
      if (audio_out_data !== cur_sample) begin
         prev_sample = cur_sample;
         cur_sample = audio_out_data;
         change_id++;
      end
   end

   ////////////////////
   // capture check
   ////////////////////

   always @(posedge clk) begin
      if (!reset && ready) begin
         ready_seen++;
         if (ready_seen >= 2 && codec_left_count >= 1 &&
             audio_in_data !== codec_left[19:4]) begin
            $display("Mismatch audio_in_data: got %h expected %h",
                     audio_in_data, codec_left[19:4]);
            error_count++;
         end
      end
   end

   ////////////////////
   // frame decoder
   ////////////////////

   task automatic check_frame();
      logic [23:0] got_cmd;
      logic found;
      ac97_link_pkg::slot_word_t slot1;
      ac97_link_pkg::slot_word_t slot2;
      ac97_link_pkg::slot_word_t left;
      ac97_link_pkg::slot_word_t right;
      ac97_link_pkg::slot_word_t want;
      slot1 = slot_field(frame_bits, `AC97_SLOT1_FIRST);
      slot2 = slot_field(frame_bits, `AC97_SLOT2_FIRST);
      left  = slot_field(frame_bits, `AC97_SLOT3_FIRST);
      right = slot_field(frame_bits, `AC97_SLOT4_FIRST);
      frames_decoded++;
      if (frame_bits[4:0] !== 5'b11111 && frame_bits[4:0] !== 5'b11001) begin
         $display("Mismatch tag: got %h expected %h or %h", frame_bits[4:0], 5'h1F, 5'h19);
         error_count++;
      end
      if (frame_bits[1]) begin
         got_cmd = {slot1[19:12], slot2[19:4]};
         found = 1'b0;
         for (int s = 0; s < 16; s++) begin
            if (expected_command(s, frame_volume, frame_source) == got_cmd) begin
               found = 1'b1;
               if (is_write_step(s))
                  seen_write[s] = 1'b1;
            end
         end
         // low bits of both command slots are reserved
         if (!found || slot1[11:0] !== 12'h000 || slot2[3:0] !== 4'h0) begin
            $display("Mismatch command_address/command_data: got %h/%h, no step fits",
                     slot1, slot2);
            error_count++;
         end
      end
      want = expected_pcm_slot(frame_cur);
      // a frame right after a change may still carry the old sample
      if (!(left === want || (frame_age == 0 && left === expected_pcm_slot(frame_prev)))) begin
         $display("Mismatch left_slot: got %h expected %h", left, want);
         error_count++;
      end
      if (!(right === want || (frame_age == 0 && right === expected_pcm_slot(frame_prev)))) begin
         $display("Mismatch right_slot: got %h expected %h", right, want);
         error_count++;
      end
   endtask

   always @(negedge ac97_bit_clock) begin
      if (!audio_reset_b) begin
         synced = 1'b0;
         prev_synch = 1'b0;
         high_len = 0;
      end else begin
         if (ac97_synch)
            high_len++;
         if (prev_synch && !ac97_synch) begin
            if (high_len != `AC97_SYNC_BITS) begin
               $display("ac97_synch high for %0d bit clocks instead of 16", high_len);
               error_count++;
            end
            high_len = 0;
         end
         if (ac97_synch && !prev_synch) begin
            // this sample is bit 255 of the frame before
            if (synced) begin
               frame_bits[255] = ac97_sdata_out;
               if (pos + 1 != `AC97_FRAME_BITS) begin
                  $display("ac97_synch rises %0d bit clocks apart instead of 256", pos + 1);
                  error_count++;
               end
               check_frame();
            end
            synced = 1'b1;
            pos = 0;
            if (seen_change_id != change_id) begin
               seen_change_id = change_id;
               age = 0;
            end else begin
               age++;
            end
            frame_age = age;
            frame_cur = cur_sample;
            frame_prev = prev_sample;
            frame_volume = volume;
            frame_source = record_source;
         end else if (synced) begin
            pos++;
            if (pos <= 255)
               frame_bits[pos-1] = ac97_sdata_out;
         end
         prev_synch = ac97_synch;
      end
   end

   // end of run checks
   always @(posedge run_done) begin
      if (!reset_b_rise_ok) begin
         $display("audio_reset_b never rose at the expected time");
         error_count++;
      end
      if (frames_decoded < 32) begin
         $display("only %0d frames decoded, 32 needed", frames_decoded);
         error_count++;
      end
      for (int s = 0; s < 16; s++) begin
         if (is_write_step(s) && !seen_write[s]) begin
            $display("write command of step %0d was never sent", s);
            error_count++;
         end
      end
   end

endmodule

`default_nettype wire

//--- bench/ac97_audio_assertions.sv
// concurrent assertions on the ac97 controller
// ready pulse width and spacing, sync width, codec reset release

`timescale 1ns/1ps
`default_nettype none

`include "ac97_params.svh"

module ac97_audio_assertions (
   input logic clk,
   input logic reset,
   input logic ready,
   input logic audio_reset_b,
   input logic ac97_bit_clock,
   input logic ac97_synch
);

   // read by the testbench for the closing line
   int failure_count = 0;

   // clk cycles since the last ready pulse, stops at one frame's bit count
   int unsigned ready_gap = 0;

   always @(posedge clk) begin
      if (reset || ready)
         ready_gap <= 0;
      else if (ready_gap < `AC97_FRAME_BITS)
         ready_gap <= ready_gap + 1;
   end

   // one clk wide pulse per frame, never two close together
   ready_single_cycle: assert property (@(posedge clk) disable iff (reset)
      ready |-> ready_gap == `AC97_FRAME_BITS)
      else begin
         failure_count++;
         $error("ready pulsed again less than a frame after the last pulse");
      end

   // sync covers the 16 tag bits
   synch_width: assert property (@(posedge ac97_bit_clock) disable iff (!audio_reset_b)
      $rose(ac97_synch) |-> ##15 ac97_synch ##1 !ac97_synch)
      else begin
         failure_count++;
         $error("ac97_synch was not high for 16 bit clocks");
      end

   // codec only goes back into reset from the clk side reset
   reset_b_fall: assert property (@(posedge clk)
      $fell(audio_reset_b) |-> $past(reset))
      else begin
         failure_count++;
         $error("audio_reset_b fell while reset was low");
      end

endmodule

`default_nettype wire

//--- logic/ac97_audio_top.sv
// ac97 mono audio controller, clk side bridge
// codec reset hold counter
// frame_ready synchronizer and ready pulse
// playback sample register
// transmitter, receiver and init sequencer

`timescale 1ns/1ps
`default_nettype none

`include "ac97_params.svh"

module ac97_audio_top (
   input  logic                         clk,
   input  logic                         reset,
   input  codec_reg_pkg::volume_t       volume,
   input  codec_reg_pkg::rec_source_t   record_source,
   input  ac97_link_pkg::pcm_sample_t   audio_out_data,
   output ac97_link_pkg::pcm_sample_t   audio_in_data,
   output logic                         ready,
   output logic                         audio_reset_b,
   input  logic                         ac97_bit_clock,
   input  logic                         ac97_sdata_in,
   output logic                         ac97_sdata_out,
   output logic                         ac97_synch
);

   localparam int HOLD_LAST = `AC97_RESET_HOLD - 1;

   logic [$clog2(`AC97_RESET_HOLD)-1:0] hold_count;
   logic link_reset;

   logic frame_ready;
   logic [2:0] ready_sync;

   ac97_link_pkg::pcm_sample_t out_sample;
   ac97_link_pkg::slot_word_t out_slot;
   ac97_link_pkg::slot_word_t left_slot;
   ac97_link_pkg::bit_index_t bit_index;

   codec_reg_pkg::reg_addr_t command_address;
   codec_reg_pkg::reg_data_t command_data;
   logic command_valid;

   ////////////////////
   // codec reset
   ////////////////////

   // hold the codec off for a while after reset
   always_ff @(posedge clk) begin
      if (reset) begin
         hold_count    <= '0;
         audio_reset_b <= 1'b0;
      end else if (hold_count == HOLD_LAST) begin
         audio_reset_b <= 1'b1;
      end else begin
         hold_count <= hold_count + 1'b1;
      end
   end

   // link restarts together with the codec
   assign link_reset = ~audio_reset_b;

   ////////////////////
   // ready into clk
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset)
         ready_sync <= '0;
      else
         ready_sync <= {ready_sync[1:0], frame_ready};
   end

   // rising edge after two flops
   assign ready = ready_sync[1] & ~ready_sync[2];

   // playback sample, held one frame
   always_ff @(posedge clk) begin
      if (reset)
         out_sample <= '0;
      else if (ready)
         out_sample <= audio_out_data;
   end

   // mono, same left-justified word both channels
   assign out_slot = {out_sample, 4'h0};

   // left capture done long before ready rises
   assign audio_in_data = left_slot[`AC97_SLOT_BITS-1:`AC97_SLOT_BITS-16];

   ac97_frame_tx ac97_frame_tx_i (
      .ac97_bit_clock  (ac97_bit_clock),
      .reset           (link_reset),
      .command_address (command_address),
      .command_data    (command_data),
      .command_valid   (command_valid),
      .left_data       (out_slot),
      .right_data      (out_slot),
      .frame_ready     (frame_ready),
      .bit_index       (bit_index),
      .ac97_sdata_out  (ac97_sdata_out),
      .ac97_synch      (ac97_synch)
   );

   // right channel capture not used by the mono bridge
   ac97_frame_rx ac97_frame_rx_i (
      .ac97_bit_clock (ac97_bit_clock),
      .bit_index      (bit_index),
      .ac97_sdata_in  (ac97_sdata_in),
      .left_slot      (left_slot),
      .right_slot     ()
   );

   codec_init_sequencer codec_init_sequencer_i (
      .clk             (clk),
      .reset           (reset),
      .ready           (ready),
      .volume          (volume),
      .record_source   (record_source),
      .command_address (command_address),
      .command_data    (command_data),
      .command_valid   (command_valid)
   );

endmodule

`default_nettype wire

//--- logic/codec_init_sequencer.sv
// codec register command sequence
// one step per frame, 16 steps then wrap
// volume and record source taken live

`timescale 1ns/1ps
`default_nettype none

module codec_init_sequencer (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         ready,
   input  codec_reg_pkg::volume_t       volume,
   input  codec_reg_pkg::rec_source_t   record_source,
   output codec_reg_pkg::reg_addr_t     command_address,
   output codec_reg_pkg::reg_data_t     command_data,
   output logic                         command_valid
);

   codec_reg_pkg::init_step_e step;

   // codec wants attenuation, 0 is loudest
   codec_reg_pkg::volume_t attenuation;

   assign attenuation = 5'd31 - volume;

   ////////////////////
   // step counter
   ////////////////////

   // 4 bit step wraps 15 to 0 on its own
   always_ff @(posedge clk) begin
      if (reset) begin
         step          <= codec_reg_pkg::read_id_0;
         command_valid <= 1'b0;
      end else begin
         if (ready)
            step <= codec_reg_pkg::init_step_e'(step + 4'd1);
         // valid from the first step on
         if (step == codec_reg_pkg::read_id_0)
            command_valid <= 1'b1;
      end
   end

   ////////////////////
   // command select
   ////////////////////

   always_ff @(posedge clk) begin
      case (step)
         codec_reg_pkg::hp_volume: begin
            // same attenuation both channels
            command_address <= 8'h04;
            command_data    <= {3'b000, attenuation, 3'b000, attenuation};
         end
         codec_reg_pkg::pcm_volume: begin
            command_address <= 8'h18;
            command_data    <= 16'h0808;
         end
         codec_reg_pkg::rec_select: begin
            command_address <= 8'h1A;
            command_data    <= {5'b00000, record_source, 5'b00000, record_source};
         end
         codec_reg_pkg::rec_gain: begin
            // max record gain
            command_address <= 8'h1C;
            command_data    <= 16'h0F0F;
         end
         codec_reg_pkg::mic_gain: begin
            // +20 dB boost
            command_address <= 8'h0E;
            command_data    <= 16'h8048;
         end
         codec_reg_pkg::beep_volume: begin
            command_address <= 8'h0A;
            command_data    <= 16'h0000;
         end
         codec_reg_pkg::pcm_bypass: begin
            command_address <= 8'h20;
            command_data    <= 16'h8000;
         end
         default: begin
            // read of the reset register, harmless filler
            command_address <= 8'h80;
            command_data    <= 16'h0000;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- logic/ac97_frame_rx.sv
// ac97 frame receiver
// falling-edge capture of left and right pcm slots

`timescale 1ns/1ps
`default_nettype none

`include "ac97_params.svh"

module ac97_frame_rx (
   input  logic                       ac97_bit_clock,
   input  ac97_link_pkg::bit_index_t  bit_index,
   input  logic                       ac97_sdata_in,
   output ac97_link_pkg::slot_word_t  left_slot,
   output ac97_link_pkg::slot_word_t  right_slot
);

   // capture windows, one bit behind the transmit slots
   localparam int LEFT_LO  = `AC97_SLOT3_FIRST + `AC97_RX_OFFSET;
   localparam int LEFT_HI  = LEFT_LO + `AC97_SLOT_BITS - 1;
   localparam int RIGHT_LO = `AC97_SLOT4_FIRST + `AC97_RX_OFFSET;
   localparam int RIGHT_HI = RIGHT_LO + `AC97_SLOT_BITS - 1;

   logic in_left;
   logic in_right;

   assign in_left  = (bit_index >= LEFT_LO) && (bit_index <= LEFT_HI);
   assign in_right = (bit_index >= RIGHT_LO) && (bit_index <= RIGHT_HI);

   ////////////////////
   // shift in
   ////////////////////

   // codec drives on the rising edge, sample in the middle of the bit
   always_ff @(negedge ac97_bit_clock) begin
      if (in_left)
         left_slot <= {left_slot[`AC97_SLOT_BITS-2:0], ac97_sdata_in};
      if (in_right)
         right_slot <= {right_slot[`AC97_SLOT_BITS-2:0], ac97_sdata_in};
   end

endmodule

`default_nettype wire

//--- logic/ac97_frame_tx.sv
// ac97 frame transmitter on the bit clock
// reset synchronizer, frame counter
// sync and frame_ready windows
// end-of-frame latch and slot serializer

`timescale 1ns/1ps
`default_nettype none

`include "ac97_params.svh"

module ac97_frame_tx (
   input  logic                       ac97_bit_clock,
   input  logic                       reset,
   input  codec_reg_pkg::reg_addr_t   command_address,
   input  codec_reg_pkg::reg_data_t   command_data,
   input  logic                       command_valid,
   input  ac97_link_pkg::slot_word_t  left_data,
   input  ac97_link_pkg::slot_word_t  right_data,
   output logic                       frame_ready,
   output ac97_link_pkg::bit_index_t  bit_index,
   output logic                       ac97_sdata_out,
   output logic                       ac97_synch
);

   // two flops, reset comes from the clk side
   logic reset_meta;
   logic link_reset;

   ac97_link_pkg::bit_index_t bit_count;

   // frame latch
   ac97_link_pkg::slot_word_t l_cmd_addr;
   ac97_link_pkg::slot_word_t l_cmd_data;
   ac97_link_pkg::slot_word_t l_left_data;
   ac97_link_pkg::slot_word_t l_right_data;
   logic l_cmd_v;

   // next serial bit
   logic tx_bit;

   // pick one slot bit, msb at the slot's first index
   function automatic logic slot_bit(input ac97_link_pkg::slot_word_t word,
                                     input ac97_link_pkg::bit_index_t first,
                                     input ac97_link_pkg::bit_index_t index);
      logic [4:0] pos;
      pos = 5'(`AC97_SLOT_BITS - 1) - 5'(index - first);
      return word[pos];
   endfunction

   always_ff @(posedge ac97_bit_clock) begin
      reset_meta <= reset;
      link_reset <= reset_meta;
   end

   ////////////////////
   // frame timing
   ////////////////////

   always_ff @(posedge ac97_bit_clock) begin
      if (link_reset) begin
         bit_count   <= '0;
         ac97_synch  <= 1'b0;
         frame_ready <= 1'b0;
      end else begin
         bit_count <= bit_count + 8'd1;
         // sync leads the frame by one bit, high over the tag slot
         if (bit_count == `AC97_FRAME_BITS - 1)
            ac97_synch <= 1'b1;
         if (bit_count == `AC97_SYNC_BITS - 1)
            ac97_synch <= 1'b0;
         if (bit_count == `AC97_READY_SET)
            frame_ready <= 1'b1;
         if (bit_count == `AC97_READY_CLR)
            frame_ready <= 1'b0;
      end
   end

   // user data taken once per frame, first frame goes out empty
   always_ff @(posedge ac97_bit_clock) begin
      if (link_reset) begin
         l_cmd_v      <= 1'b0;
         l_left_data  <= '0;
         l_right_data <= '0;
      end else if (bit_count == `AC97_FRAME_BITS - 1) begin
         l_cmd_v      <= command_valid;
         l_left_data  <= left_data;
         l_right_data <= right_data;
      end
   end

   // command words left justified in their slots
   always_ff @(posedge ac97_bit_clock) begin
      if (bit_count == `AC97_FRAME_BITS - 1) begin
         l_cmd_addr <= {command_address, 12'h000};
         l_cmd_data <= {command_data, 4'h0};
      end
   end

   ////////////////////
   // serializer
   ////////////////////

   always_comb begin
      tx_bit = 1'b0;
      if (bit_count < `AC97_SLOT1_FIRST) begin
         // tag slot
         case (bit_count)
            8'd0:       tx_bit = 1'b1;
            8'd1, 8'd2: tx_bit = l_cmd_v;
            // left and right always valid
            8'd3, 8'd4: tx_bit = 1'b1;
            default:    tx_bit = 1'b0;
         endcase
      end else if (bit_count < `AC97_SLOT2_FIRST) begin
         tx_bit = l_cmd_v & slot_bit(l_cmd_addr, 8'(`AC97_SLOT1_FIRST), bit_count);
      end else if (bit_count < `AC97_SLOT3_FIRST) begin
         tx_bit = l_cmd_v & slot_bit(l_cmd_data, 8'(`AC97_SLOT2_FIRST), bit_count);
      end else if (bit_count < `AC97_SLOT4_FIRST) begin
         tx_bit = slot_bit(l_left_data, 8'(`AC97_SLOT3_FIRST), bit_count);
      end else if (bit_count < `AC97_SLOT4_FIRST + `AC97_SLOT_BITS) begin
         tx_bit = slot_bit(l_right_data, 8'(`AC97_SLOT4_FIRST), bit_count);
      end
      // slots 5 to 12 stay zero
   end

   // line bit lags the index by one clock
   always_ff @(posedge ac97_bit_clock) begin
      if (link_reset)
         ac97_sdata_out <= 1'b0;
      else
         ac97_sdata_out <= tx_bit;
   end

   assign bit_index = bit_count;

endmodule

`default_nettype wire

//--- logic/codec_reg_pkg.sv
// codec register types
// address, data, volume, record source
// init sequencer step encoding

`default_nettype none

package codec_reg_pkg;

   // bit 7 set means read
   typedef logic [7:0] reg_addr_t;
   typedef logic [15:0] reg_data_t;

   // 31 is loudest
   typedef logic [4:0] volume_t;

   // codec record select, 0 is mic
   typedef logic [2:0] rec_source_t;

   ////////////////////
   // init steps
   ////////////////////

   // one command per frame
   typedef enum logic [3:0] {
      read_id_0   = 4'd0,
      read_id_1   = 4'd1,
      idle_2      = 4'd2,
      hp_volume   = 4'd3,
      idle_4      = 4'd4,
      pcm_volume  = 4'd5,
      rec_select  = 4'd6,
      rec_gain    = 4'd7,
      idle_8      = 4'd8,
      mic_gain    = 4'd9,
      beep_volume = 4'd10,
      pcm_bypass  = 4'd11,
      idle_12     = 4'd12,
      idle_13     = 4'd13,
      idle_14     = 4'd14,
      idle_15     = 4'd15
   } init_step_e;

endpackage

`default_nettype wire

//--- logic/ac97_link_pkg.sv
// serial link types for the ac97 frame
// slot word, bit position, pcm sample

`default_nettype none

`include "ac97_params.svh"

package ac97_link_pkg;

   ////////////////////
   // link widths
   ////////////////////

   // one data slot, msb goes out first
   typedef logic [`AC97_SLOT_BITS-1:0] slot_word_t;

   // position inside the frame, 0 is first tag bit
   typedef logic [$clog2(`AC97_FRAME_BITS)-1:0] bit_index_t;

   // 16 bit audio, sits in the top of a slot
   typedef logic [15:0] pcm_sample_t;

endpackage

`default_nettype wire

//--- logic/ac97_params.svh
// ac97 link constants
// frame length and slot layout
// sync and ready windows, receive lag
// codec reset hold in clk cycles

`ifndef AC97_PARAMS_SVH
`define AC97_PARAMS_SVH

////////////////////
// frame layout
////////////////////

// bit clocks per frame, 13 slots incl. tag
`define AC97_FRAME_BITS 256

// sync high over the whole tag slot
`define AC97_SYNC_BITS 16

// frame_ready window, set late in the frame, cleared just after the start
`define AC97_READY_SET 128
`define AC97_READY_CLR 2

// first bit of each used slot
`define AC97_SLOT1_FIRST 16
`define AC97_SLOT2_FIRST 36
`define AC97_SLOT3_FIRST 56
`define AC97_SLOT4_FIRST 76

// data slot width
`define AC97_SLOT_BITS 20

// codec data lags the index by one bit
`define AC97_RX_OFFSET 1

////////////////////
// codec reset
////////////////////

// reset_b held low this many clk cycles
`define AC97_RESET_HOLD 1024

`endif
